//--- bram_wb8.sv
`timescale 1ns/1ps
`default_nettype none

module bram_wb8 #(
    parameter int ADDR_BITS = 10
) (
    input  logic clk,
    input  logic rst_n_i,
    wb8_if.slave bus
);
    import soc_pkg::*;

    logic [DATA_W-1:0]    mem [2**ADDR_BITS];
    logic [ADDR_BITS-1:0] idx;
    logic                 access;

    // upper address bits are ignored, so ram aliases
    assign idx    = bus.adr[ADDR_BITS-1:0];
    assign access = bus.stb && !bus.ack;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= access;
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            if (bus.we) begin
                mem[idx] <= bus.dat_w;
            end
            bus.dat_r <= mem[idx];
        end
    end

endmodule

`default_nettype wire

//--- leds_wb8.sv
`timescale 1ns/1ps
`default_nettype none

module leds_wb8 (
    input  logic                       clk,
    input  logic                       rst_n_i,
    wb8_if.slave                       bus,
    output logic [soc_pkg::DATA_W-1:0] leds_o
);
    import soc_pkg::*;

    logic [DATA_W-1:0] leds_q;
    logic              access;

    assign access = bus.stb && !bus.ack;

    // any offset in the window hits the same byte
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bus.ack <= 1'b0;
            leds_q  <= '0;
        end else begin
            bus.ack <= access;
            if (access && bus.we) begin
                leds_q <= bus.dat_w;
            end
        end
    end

    assign bus.dat_r = leds_q;
    assign leds_o    = leds_q;

endmodule

`default_nettype wire

//--- prng_wb8.sv
`timescale 1ns/1ps
`default_nettype none

module prng_wb8 (
    input  logic clk,
    input  logic rst_n_i,
    wb8_if.slave bus
);
    import soc_pkg::*;

    logic [31:0] state_q;
    logic [31:0] seed_w;
    logic [31:0] step_w;
    logic [1:0]  off;
    logic        access;

    assign off    = bus.adr[1:0];
    assign access = bus.stb && !bus.ack;

    // state with the addressed byte replaced
    always_comb begin
        seed_w = state_q;
        seed_w[{off, 3'b000} +: 8] = bus.dat_w;
    end

    // one galois step, shifting right
    assign step_w = {1'b0, state_q[31:1]} ^ (state_q[0] ? PRNG_POLY : 32'd0);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bus.ack <= 1'b0;
            state_q <= 32'h1;
        end else begin
            bus.ack <= access;
            if (access && bus.we) begin
                // zero would lock up the lfsr
                state_q <= (seed_w == 32'd0) ? 32'h1 : seed_w;
            end else if (access && off == 2'd0) begin
                state_q <= step_w;
            end
        end
    end

    // sampled before the step so a read sees the old low byte
    always_ff @(posedge clk) begin
        if (access) begin
            bus.dat_r <= state_q[{off, 3'b000} +: 8];
        end
    end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_soc_top -f soc_top.f

# the log decides the result, so the simulator status is not used here
./obj_dir/Vtb_soc_top | tee sim.log

if grep -qF "*** TEST FAILED ***" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -qF "*** TEST PASSED ***" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi

//--- soc_pkg.sv
`default_nettype none

package soc_pkg;

    // bus widths
    localparam int DATA_W = 8;
    localparam int ADR_W  = 32;

    // peripheral regions, anything else falls through to ram
    // leds: 0xFFFFFFF0 - 0xFFFFFFFF
    localparam logic [ADR_W-1:0] LEDS_BASE  = 32'hFFFF_FFF0;
    // timer: 0xFFFFFD00 - 0xFFFFFDFF
    localparam logic [ADR_W-1:0] TIMER_BASE = 32'hFFFF_FD00;
    // prng: 0xFFFFFE00 - 0xFFFFFEFF
    localparam logic [ADR_W-1:0] PRNG_BASE  = 32'hFFFF_FE00;

    // timer register offsets
    localparam logic [1:0] TIMER_REG_RELOAD_LO = 2'd0;
    localparam logic [1:0] TIMER_REG_RELOAD_HI = 2'd1;
    localparam logic [1:0] TIMER_REG_CTRL      = 2'd2;
    localparam logic [1:0] TIMER_REG_STATUS    = 2'd3;

    // galois mask for taps 32,31,29,1 (maximal length)
    localparam logic [31:0] PRNG_POLY = 32'hD000_0001;

endpackage

`default_nettype wire

//--- soc_top.f
soc_pkg.sv
wb8_if.sv
wb8_decoder.sv
bram_wb8.sv
leds_wb8.sv
timer_wb8.sv
prng_wb8.sv
soc_top.sv
tb_soc_top.sv

//--- soc_top.sv
`timescale 1ns/1ps
`default_nettype none

module soc_top #(
    parameter int RAM_ADDR_BITS = 10
) (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       wb_stb_i,
    input  logic                       wb_we_i,
    input  logic [soc_pkg::ADR_W-1:0]  wb_adr_i,
    input  logic [soc_pkg::DATA_W-1:0] wb_dat_i,
    output logic [soc_pkg::DATA_W-1:0] wb_dat_o,
    output logic                       wb_ack_o,
    output logic [soc_pkg::DATA_W-1:0] leds_o,
    output logic                       timer_irq_o
);

    wb8_if cpu_bus ();
    wb8_if ram_bus ();
    wb8_if leds_bus ();
    wb8_if timer_bus ();
    wb8_if prng_bus ();

    // external master side
    assign cpu_bus.stb   = wb_stb_i;
    assign cpu_bus.we    = wb_we_i;
    assign cpu_bus.adr   = wb_adr_i;
    assign cpu_bus.dat_w = wb_dat_i;
    assign wb_dat_o      = cpu_bus.dat_r;
    assign wb_ack_o      = cpu_bus.ack;

    wb8_decoder i_decoder (
        .cpu   (cpu_bus),
        .ram   (ram_bus),
        .leds  (leds_bus),
        .timer (timer_bus),
        .prng  (prng_bus)
    );

    bram_wb8 #(
        .ADDR_BITS (RAM_ADDR_BITS)
    ) i_ram (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .bus     (ram_bus)
    );

    leds_wb8 i_leds (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .bus     (leds_bus),
        .leds_o  (leds_o)
    );

    timer_wb8 i_timer (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .bus     (timer_bus),
        .irq_o   (timer_irq_o)
    );

    prng_wb8 i_prng (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .bus     (prng_bus)
    );

endmodule

`default_nettype wire

//--- tb_soc_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_soc_top;
    import soc_pkg::*;

    localparam int RAM_BITS     = 10;
    localparam int RAM_SIZE     = 2**RAM_BITS;
    localparam int CYCLE_LIMIT  = 20000;
    localparam int ACK_WAIT_MAX = 8;
    // stimulus generator taps 32,22,2,1
    localparam logic [31:0] STIM_POLY = 32'h8020_0003;

    logic        clk;
    logic        rst_n_i;
    logic        wb_stb_i;
    logic        wb_we_i;
    logic [31:0] wb_adr_i;
    logic [7:0]  wb_dat_i;
    logic [7:0]  wb_dat_o;
    logic        wb_ack_o;
    logic [7:0]  leds_o;
    logic        timer_irq_o;

    logic [31:0] stim_state;
    int          cycle_cnt;
    int          ack_cycle;

    // reference model
    logic [7:0]  ram_model [RAM_SIZE];
    bit          ram_valid [RAM_SIZE];
    int          written_q [$];
    logic [7:0]  leds_model;
    logic [15:0] reload_model;
    logic [31:0] prng_model;

    soc_top i_dut (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .wb_stb_i    (wb_stb_i),
        .wb_we_i     (wb_we_i),
        .wb_adr_i    (wb_adr_i),
        .wb_dat_i    (wb_dat_i),
        .wb_dat_o    (wb_dat_o),
        .wb_ack_o    (wb_ack_o),
        .leds_o      (leds_o),
        .timer_irq_o (timer_irq_o)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        assert (cycle_cnt < CYCLE_LIMIT) else begin
            report_fatal("timeout: the run did not finish within the cycle limit");
        end
    end

    task automatic report_fatal(input string line);
        $display("%s", line);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
        assert (got === exp) else begin
            report_fatal($sformatf("MISMATCH at %0t: %s got %02h expected %02h",
                                   $time, what, got, exp));
        end
    endtask

    // right-shifting galois step for stimulus and prng model
    function automatic logic [31:0] galois_step(input logic [31:0] s, input logic [31:0] poly);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ poly;
        end
        return n;
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            stim_state = galois_step(stim_state, STIM_POLY);
            val = {val[30:0], stim_state[0]};
        end
    endtask

    function automatic logic [7:0] byte_of(input logic [31:0] w, input logic [1:0] i);
        case (i)
            2'd0:    return w[7:0];
            2'd1:    return w[15:8];
            2'd2:    return w[23:16];
            default: return w[31:24];
        endcase
    endfunction

    // one bus access between two falling edges
    task automatic bus_cycle(input logic we, input logic [31:0] adr, input logic [7:0] wdata,
                             output logic [7:0] rdata);
        int waited;
        waited = 0;
        assert (wb_ack_o === 1'b0) else begin
            report_fatal("acknowledge was high before the strobe was raised");
        end
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_dat_i = wdata;
        do begin
            @(negedge clk);
            waited++;
        end while (wb_ack_o !== 1'b1 && waited < ACK_WAIT_MAX);
        assert (wb_ack_o === 1'b1) else begin
            report_fatal($sformatf("no acknowledge came for address %08h", adr));
        end
        assert (waited == 1) else begin
            report_fatal($sformatf("MISMATCH at %0t: acknowledge after %0d cycles, expected 1",
                                   $time, waited));
        end
        ack_cycle = cycle_cnt;
        rdata     = wb_dat_o;
        wb_stb_i  = 1'b0;
        wb_we_i   = 1'b0;
        // idle cycle lets the slave drop ack
        @(negedge clk);
        assert (wb_ack_o === 1'b0) else begin
            report_fatal("acknowledge stayed high for more than one cycle");
        end
    endtask

    task automatic bus_write(input logic [31:0] adr, input logic [7:0] data);
        logic [7:0] ignored;
        bus_cycle(1'b1, adr, data, ignored);
    endtask

    task automatic bus_read(input logic [31:0] adr, output logic [7:0] data);
        bus_cycle(1'b0, adr, 8'h00, data);
    endtask

    // keep random high bits out of the peripheral regions
    function automatic logic [31:0] ram_address(input logic [9:0] idx, input logic [21:0] hi);
        logic [31:0] a;
        a = {hi, idx};
        if (a[31:12] == 20'hFFFFF) begin
            a[31] = 1'b0;
        end
        return a;
    endfunction

    task automatic ram_random_write;
        logic [31:0] r;
        logic [9:0]  idx;
        rand_bits(18, r);
        idx = r[17:8];
        bus_write(ram_address(idx, 22'd0), r[7:0]);
        ram_model[idx] = r[7:0];
        if (!ram_valid[idx]) begin
            ram_valid[idx] = 1'b1;
            written_q.push_back(int'(idx));
        end
    endtask

    task automatic ram_read_check(input logic [9:0] idx, input logic [21:0] hi);
        logic [7:0] rd;
        bus_read(ram_address(idx, hi), rd);
        check_byte(rd, ram_model[idx], $sformatf("ram[%03h]", idx));
    endtask

    // aliased high address on about half the reads
    task automatic ram_random_read;
        logic [31:0] r;
        logic [31:0] hi;
        int          pos;
        rand_bits(16, r);
        rand_bits(23, hi);
        pos = int'(r[15:0]) % written_q.size();
        ram_read_check(10'(written_q[pos]), hi[22] ? hi[21:0] : 22'd0);
    endtask

    task automatic timer_write(input logic [1:0] off, input logic [7:0] data);
        bus_write({TIMER_BASE[31:8], 6'd0, off}, data);
    endtask

    task automatic timer_read_check(input logic [1:0] off, input logic [7:0] exp);
        logic [7:0] rd;
        bus_read({TIMER_BASE[31:8], 6'd0, off}, rd);
        check_byte(rd, exp, $sformatf("timer register %0d", off));
    endtask

    task automatic prng_write(input logic [5:0] page, input logic [1:0] off,
                              input logic [7:0] data);
        logic [31:0] s;
        bus_write({PRNG_BASE[31:8], page, off}, data);
        s = prng_model;
        case (off)
            2'd0:    s[7:0]   = data;
            2'd1:    s[15:8]  = data;
            2'd2:    s[23:16] = data;
            default: s[31:24] = data;
        endcase
        prng_model = (s == 32'd0) ? 32'h1 : s;
    endtask

    task automatic prng_read_check(input logic [5:0] page, input logic [1:0] off);
        logic [7:0] rd;
        bus_read({PRNG_BASE[31:8], page, off}, rd);
        check_byte(rd, byte_of(prng_model, off), $sformatf("prng byte %0d", off));
        if (off == 2'd0) begin
            prng_model = galois_step(prng_model, PRNG_POLY);
        end
    endtask

    task automatic wait_irq(input int from_cycle, input int reload, output int rise_cycle);
        int delta;
        while (timer_irq_o !== 1'b1 && cycle_cnt - from_cycle <= reload + 3) begin
            @(negedge clk);
        end
        delta = cycle_cnt - from_cycle;
        assert (timer_irq_o === 1'b1) else begin
            report_fatal("timer interrupt did not rise within its window");
        end
        assert (delta >= reload + 1 && delta <= reload + 3) else begin
            report_fatal($sformatf(
                "MISMATCH at %0t: interrupt after %0d cycles, expected %0d to %0d",
                $time, delta, reload + 1, reload + 3));
        end
        rise_cycle = cycle_cnt;
    endtask

    task automatic test_leds;
        logic [31:0] r;
        logic [7:0]  rd;
        repeat (20) begin
            rand_bits(12, r);
            bus_write({LEDS_BASE[31:4], r[3:0]}, r[11:4]);
            leds_model = r[11:4];
            check_byte(leds_o, leds_model, "leds_o after write");
            rand_bits(4, r);
            bus_read({LEDS_BASE[31:4], r[3:0]}, rd);
            check_byte(rd, leds_model, "led register read");
        end
        // ram must be untouched
        repeat (50) ram_random_read();
    endtask

    task automatic test_prng;
        logic [31:0] seed;
        rand_bits(32, seed);
        if (seed == 32'd0) begin
            seed = 32'h1;
        end
        for (int i = 0; i < 4; i++) begin
            prng_write(6'd0, 2'(i), byte_of(seed, 2'(i)));
        end
        repeat (50) prng_read_check(6'd0, 2'd0);
        // upper bytes twice without stepping
        for (int i = 0; i < 6; i++) begin
            prng_read_check(6'd0, 2'(3 - i % 3));
        end
    endtask

    task automatic test_timer;
        logic [31:0] r;
        int          reload;
        int          rise;
        rand_bits(6, r);
        reload = 4 + int'(r[5:0]) % 57;
        timer_write(TIMER_REG_RELOAD_LO, 8'(reload));
        timer_write(TIMER_REG_RELOAD_HI, 8'h00);
        reload_model = 16'(reload);
        timer_write(TIMER_REG_CTRL, 8'h03);
        wait_irq(ack_cycle, reload, rise);
        timer_read_check(TIMER_REG_STATUS, 8'h01);
        timer_write(TIMER_REG_STATUS, 8'h01);
        check_byte({7'd0, timer_irq_o}, 8'h00, "irq after status clear");
        wait_irq(rise, reload, rise);
        timer_read_check(TIMER_REG_CTRL, 8'h03);
        // stop and clear before the mixed traffic
        timer_write(TIMER_REG_CTRL, 8'h00);
        timer_write(TIMER_REG_STATUS, 8'h01);
        check_byte({7'd0, timer_irq_o}, 8'h00, "irq after timer stop");
    endtask

    task automatic test_decode;
        logic [31:0] r;
        logic [7:0]  rd;
        repeat (200) begin
            rand_bits(20, r);
            case (r[1:0])
                2'd0: begin
                    if (r[2]) begin
                        ram_random_write();
                    end else begin
                        ram_random_read();
                    end
                end
                2'd1: begin
                    if (r[2]) begin
                        bus_write({LEDS_BASE[31:4], r[6:3]}, r[14:7]);
                        leds_model = r[14:7];
                    end else begin
                        bus_read({LEDS_BASE[31:4], r[6:3]}, rd);
                        check_byte(rd, leds_model, "led register read");
                    end
                end
                2'd2: begin
                    if (r[2]) begin
                        bus_write({TIMER_BASE[31:8], r[19:14], 1'b0, r[3]}, r[11:4]);
                        if (r[3]) begin
                            reload_model[15:8] = r[11:4];
                        end else begin
                            reload_model[7:0] = r[11:4];
                        end
                    end else begin
                        bus_read({TIMER_BASE[31:8], r[19:14], 1'b0, r[3]}, rd);
                        check_byte(rd, r[3] ? reload_model[15:8] : reload_model[7:0],
                                   "timer reload read");
                    end
                end
                default: begin
                    if (r[2]) begin
                        prng_write(r[9:4], r[11:10], r[19:12]);
                    end else begin
                        prng_read_check(r[9:4], r[11:10]);
                    end
                end
            endcase
        end
    endtask

    task automatic final_sweep;
        logic [7:0] rd;
        foreach (written_q[i]) begin
            ram_read_check(10'(written_q[i]), 22'd0);
        end
        bus_read(LEDS_BASE, rd);
        check_byte(rd, leds_model, "led register read");
        check_byte(leds_o, leds_model, "leds_o");
        timer_read_check(TIMER_REG_RELOAD_LO, reload_model[7:0]);
        timer_read_check(TIMER_REG_RELOAD_HI, reload_model[15:8]);
        timer_read_check(TIMER_REG_CTRL, 8'h00);
        timer_read_check(TIMER_REG_STATUS, 8'h00);
        for (int i = 3; i >= 0; i--) begin
            prng_read_check(6'd0, 2'(i));
        end
    endtask

    task automatic check_idle;
        check_byte(leds_o, 8'h00, "leds_o after reset");
        check_byte({7'd0, timer_irq_o}, 8'h00, "timer_irq_o after reset");
        check_byte({7'd0, wb_ack_o}, 8'h00, "wb_ack_o while idle");
    endtask

    initial begin
        clk          = 1'b0;
        rst_n_i      = 1'b0;
        wb_stb_i     = 1'b0;
        wb_we_i      = 1'b0;
        wb_adr_i     = '0;
        wb_dat_i     = '0;
        stim_state   = 32'h919a;
        cycle_cnt    = 0;
        ack_cycle    = 0;
        leds_model   = 8'h00;
        reload_model = 16'h0000;
        prng_model   = 32'h1;

        repeat (3) begin
            @(negedge clk);
            check_idle();
        end
        rst_n_i = 1'b1;
        repeat (4) begin
            @(negedge clk);
            check_idle();
        end

        repeat (300) ram_random_write();
        repeat (300) ram_random_read();
        test_leds();
        test_prng();
        test_timer();
        test_decode();
        final_sweep();

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- timer_wb8.sv
`timescale 1ns/1ps
`default_nettype none

module timer_wb8 (
    input  logic clk,
    input  logic rst_n_i,
    wb8_if.slave bus,
    output logic irq_o
);
    import soc_pkg::*;

    logic [15:0] reload_q;
    logic [15:0] count_q;
    logic        en_q;
    logic        ie_q;
    logic        pending_q;
    logic        access;
    logic        wr;
    logic [1:0]  off;

    assign access = bus.stb && !bus.ack;
    assign wr     = access && bus.we;
    assign off    = bus.adr[1:0];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bus.ack   <= 1'b0;
            reload_q  <= '0;
            count_q   <= '0;
            en_q      <= 1'b0;
            ie_q      <= 1'b0;
            pending_q <= 1'b0;
            irq_o     <= 1'b0;
        end else begin
            bus.ack <= access;

            if (wr && off == TIMER_REG_RELOAD_LO) begin
                reload_q[7:0] <= bus.dat_w;
            end
            if (wr && off == TIMER_REG_RELOAD_HI) begin
                reload_q[15:8] <= bus.dat_w;
            end
            // write 1 to clear, a wrap on the same edge wins
            if (wr && off == TIMER_REG_STATUS && bus.dat_w[0]) begin
                pending_q <= 1'b0;
            end

            if (wr && off == TIMER_REG_CTRL) begin
                en_q <= bus.dat_w[0];
                ie_q <= bus.dat_w[1];
                // enabling restarts the period
                if (bus.dat_w[0]) begin
                    count_q <= reload_q;
                end
            end else if (en_q) begin
                if (count_q == '0) begin
                    count_q   <= reload_q;
                    pending_q <= 1'b1;
                end else begin
                    count_q <= count_q - 16'd1;
                end
            end

            irq_o <= pending_q && ie_q;
        end
    end

    always_comb begin
        case (off)
            TIMER_REG_RELOAD_LO: bus.dat_r = reload_q[7:0];
            TIMER_REG_RELOAD_HI: bus.dat_r = reload_q[15:8];
            TIMER_REG_CTRL:      bus.dat_r = {6'd0, ie_q, en_q};
            default:             bus.dat_r = {7'd0, pending_q};
        endcase
    end

endmodule

`default_nettype wire

//--- wb8_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module wb8_decoder (
    wb8_if.slave  cpu,
    wb8_if.master ram,
    wb8_if.master leds,
    wb8_if.master timer,
    wb8_if.master prng
);
    import soc_pkg::*;

    logic sel_leds;
    logic sel_timer;
    logic sel_prng;
    logic sel_ram;

    // leds own a 16 byte window, timer and prng 256 bytes each
    assign sel_leds  = (cpu.adr[ADR_W-1:4] == LEDS_BASE[ADR_W-1:4]);
    assign sel_timer = (cpu.adr[ADR_W-1:8] == TIMER_BASE[ADR_W-1:8]);
    assign sel_prng  = (cpu.adr[ADR_W-1:8] == PRNG_BASE[ADR_W-1:8]);
    assign sel_ram   = !(sel_leds || sel_timer || sel_prng);

    // strobe only reaches the selected slave
    assign ram.stb   = cpu.stb && sel_ram;
    assign leds.stb  = cpu.stb && sel_leds;
    assign timer.stb = cpu.stb && sel_timer;
    assign prng.stb  = cpu.stb && sel_prng;

    // broadcast the rest
    assign ram.we    = cpu.we;
    assign ram.adr   = cpu.adr;
    assign ram.dat_w = cpu.dat_w;

    assign leds.we    = cpu.we;
    assign leds.adr   = cpu.adr;
    assign leds.dat_w = cpu.dat_w;

    assign timer.we    = cpu.we;
    assign timer.adr   = cpu.adr;
    assign timer.dat_w = cpu.dat_w;

    assign prng.we    = cpu.we;
    assign prng.adr   = cpu.adr;
    assign prng.dat_w = cpu.dat_w;

    // return path from the selected slave
    always_comb begin
        cpu.dat_r = ram.dat_r;
        cpu.ack   = ram.ack;
        if (sel_leds) begin
            cpu.dat_r = leds.dat_r;
            cpu.ack   = leds.ack;
        end else if (sel_timer) begin
            cpu.dat_r = timer.dat_r;
            cpu.ack   = timer.ack;
        end else if (sel_prng) begin
            cpu.dat_r = prng.dat_r;
            cpu.ack   = prng.ack;
        end
    end

endmodule

`default_nettype wire

//--- wb8_if.sv
`timescale 1ns/1ps
`default_nettype none

interface wb8_if;
    import soc_pkg::*;

    logic              stb;
    logic              we;
    logic [ADR_W-1:0]  adr;
    logic [DATA_W-1:0] dat_w;
    logic [DATA_W-1:0] dat_r;
    logic              ack;

    modport master (
        output stb,
        output we,
        output adr,
        output dat_w,
        input  dat_r,
        input  ack
    );

    modport slave (
        input  stb,
        input  we,
        input  adr,
        input  dat_w,
        output dat_r,
        output ack
    );

endinterface

`default_nettype wire
